// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Address map.
    localparam int RAM_WORDS = 256;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS) + 2;
    localparam logic [31:0] RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] IO_BASE = 32'h0001_0000;
    localparam logic [31:0] UART_BASE = 32'h0002_0000;

    // Register blocks decode the low address nibble.
    localparam int REG_ADDR_BITS = 4;
    localparam logic [REG_ADDR_BITS-1:0] IO_LEDS_OFS = 4'h0;
    localparam logic [REG_ADDR_BITS-1:0] IO_CYCLE_LO_OFS = 4'h8;
    localparam logic [REG_ADDR_BITS-1:0] IO_CYCLE_HI_OFS = 4'hC;
    localparam logic [REG_ADDR_BITS-1:0] UART_DATA_OFS = 4'h0;
    localparam logic [REG_ADDR_BITS-1:0] UART_STATUS_OFS = 4'h4;

    localparam int UART_CLKS_PER_BIT = 16;
    localparam int UART_CNT_BITS = $clog2(UART_CLKS_PER_BIT);
    localparam int UART_FIFO_DEPTH = 4;
    localparam int UART_FIFO_PTR_BITS = $clog2(UART_FIFO_DEPTH);
    localparam int UART_FIFO_CNT_BITS = UART_FIFO_PTR_BITS + 1;

    typedef enum logic [1:0] {
        SLOT_RAM,
        SLOT_IO,
        SLOT_UART,
        SLOT_NONE
    } slot_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    logic [31:0] address;
    logic sel;
    logic read;
    logic [3:0] write_mask;
    logic [31:0] write_value;
    logic [31:0] read_value;
    logic ready;

    modport host (
        output address,
        output sel,
        output read,
        output write_mask,
        output write_value,
        input read_value,
        input ready
    );

    // A target returns zero read data while its select is low.
    modport target (
        input address,
        input sel,
        input read,
        input write_mask,
        input write_value,
        output read_value,
        output ready
    );
endinterface

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
    import soc_pkg::*;
(
    input logic [31:0] address,
    input logic read,
    input logic [3:0] write_mask,
    input logic [31:0] write_value,
    mem_bus_if.host ram_bus,
    mem_bus_if.host io_bus,
    mem_bus_if.host uart_bus,
    output logic [31:0] read_value,
    output logic ready,
    output logic fault
);

    slot_e slot;
    logic req;

    always_comb begin
        if (address[31:RAM_ADDR_BITS] == RAM_BASE[31:RAM_ADDR_BITS]) begin
            slot = SLOT_RAM;
        end else if (address[31:REG_ADDR_BITS] == IO_BASE[31:REG_ADDR_BITS]) begin
            slot = SLOT_IO;
        end else if (address[31:REG_ADDR_BITS] == UART_BASE[31:REG_ADDR_BITS]) begin
            slot = SLOT_UART;
        end else begin
            slot = SLOT_NONE;
        end
    end

    // Idle cycles select nothing.
    assign req = read || (write_mask != 4'b0000);

    assign ram_bus.address = address;
    assign ram_bus.sel = req && (slot == SLOT_RAM);
    assign ram_bus.read = read;
    assign ram_bus.write_mask = write_mask;
    assign ram_bus.write_value = write_value;

    assign io_bus.address = address;
    assign io_bus.sel = req && (slot == SLOT_IO);
    assign io_bus.read = read;
    assign io_bus.write_mask = write_mask;
    assign io_bus.write_value = write_value;

    assign uart_bus.address = address;
    assign uart_bus.sel = req && (slot == SLOT_UART);
    assign uart_bus.read = read;
    assign uart_bus.write_mask = write_mask;
    assign uart_bus.write_value = write_value;

    assign fault = req && (slot == SLOT_NONE);
    assign read_value = ram_bus.read_value | io_bus.read_value | uart_bus.read_value;
    assign ready = ram_bus.ready | io_bus.ready | uart_bus.ready | fault;

endmodule

`default_nettype wire

// ==== rtl/ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    mem_bus_if.target bus
);

    logic [31:0] mem [RAM_WORDS];
    logic [RAM_ADDR_BITS-3:0] word_addr;
    logic [31:0] read_q;
    logic ready_q;

    assign word_addr = bus.address[RAM_ADDR_BITS-1:2];

    // One-cycle ready pulse, then a gap so a held request is taken once.
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.sel && !ready_q;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus.sel && !ready_q) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.write_mask[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= bus.write_value[lane*8 +: 8];
                end
            end
            if (bus.read) begin
                read_q <= mem[word_addr];
            end
        end
    end

    assign bus.ready = bus.sel && ready_q;
    assign bus.read_value = (bus.sel && bus.read && ready_q) ? read_q : 32'h0;

endmodule

`default_nettype wire

// ==== rtl/io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_regs
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    mem_bus_if.target bus,
    output logic [7:0] leds
);

    logic [63:0] cycle;
    logic [REG_ADDR_BITS-1:0] ofs;

    assign ofs = bus.address[REG_ADDR_BITS-1:0];

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 64'h0;
            leds <= 8'h00;
        end else begin
            cycle <= cycle + 64'h1;
            if (bus.sel && bus.write_mask[0] && ofs == IO_LEDS_OFS) begin
                leds <= bus.write_value[7:0];
            end
        end
    end

    always_comb begin
        bus.read_value = 32'h0;
        if (bus.sel && bus.read) begin
            case (ofs)
                IO_LEDS_OFS: bus.read_value = {24'h0, leds};
                IO_CYCLE_LO_OFS: bus.read_value = cycle[31:0];
                IO_CYCLE_HI_OFS: bus.read_value = cycle[63:32];
                default: bus.read_value = 32'h0;
            endcase
        end
    end

    assign bus.ready = bus.sel;

endmodule

`default_nettype wire

// ==== rtl/uart_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_regs
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    mem_bus_if.target bus,
    input logic full,
    input logic empty,
    input logic busy,
    output logic push,
    output logic [7:0] push_data
);

    logic [REG_ADDR_BITS-1:0] ofs;
    logic data_wr;
    logic status_rd;
    logic accept;
    logic pending;

    assign ofs = bus.address[REG_ADDR_BITS-1:0];
    assign data_wr = bus.sel && bus.write_mask[0] && (ofs == UART_DATA_OFS);
    assign status_rd = bus.sel && bus.read && (ofs == UART_STATUS_OFS);

    // A byte in flight on push is not yet counted by the FIFO.
    assign accept = data_wr && !full && !push;
    assign pending = !empty || busy || push;

    // Stall a data write until the FIFO can take it.
    assign bus.ready = bus.sel && !(data_wr && !accept);
    assign bus.read_value = status_rd ? {30'h0, pending, full} : 32'h0;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (accept) begin
            push_data <= bus.write_value[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input logic push,
    input logic [7:0] push_data,
    input logic pop,
    output logic [7:0] pop_data,
    output logic full,
    output logic empty
);

    logic [7:0] entries [UART_FIFO_DEPTH];
    logic [UART_FIFO_PTR_BITS-1:0] wr_ptr;
    logic [UART_FIFO_PTR_BITS-1:0] rd_ptr;
    logic [UART_FIFO_CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == UART_FIFO_CNT_BITS'(UART_FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Oldest entry is always visible.
    assign pop_data = entries[rd_ptr];

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input logic empty,
    input logic [7:0] pop_data,
    output logic pop,
    output logic busy,
    output logic tx
);

    tx_state_e state;
    logic [UART_CNT_BITS-1:0] bit_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic bit_done;

    assign bit_done = (bit_cnt == UART_CNT_BITS'(UART_CLKS_PER_BIT - 1));

    // Take the next byte when idle, or right at the end of a stop bit.
    assign pop = !empty && ((state == TX_IDLE) || (state == TX_STOP && bit_done));
    assign busy = (state != TX_IDLE);

    always_comb begin
        case (state)
            TX_START: tx = 1'b0;
            TX_DATA: tx = shift[0];
            default: tx = 1'b1;
        endcase
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= 3'd0;
        end else begin
            bit_cnt <= (state == TX_IDLE || bit_done) ? '0 : bit_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (pop) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state <= TX_DATA;
                        bit_idx <= 3'd0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= pop ? TX_START : TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB leaves first.
    always_ff @(posedge pll_clk) begin
        if (pop) begin
            shift <= pop_data;
        end else if (state == TX_DATA && bit_done) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top (
    input logic pll_clk,
    input logic rst_n,
    input logic [31:0] bus_address,
    input logic bus_read,
    input logic bus_write,
    input logic [3:0] bus_write_mask,
    input logic [31:0] bus_write_value,
    output logic [31:0] bus_read_value,
    output logic bus_ready,
    output logic bus_fault,
    output logic [7:0] leds,
    output logic uart_tx
);

    mem_bus_if ram_bus ();
    mem_bus_if io_bus ();
    mem_bus_if uart_bus ();

    logic push;
    logic [7:0] push_data;
    logic pop;
    logic [7:0] pop_data;
    logic full;
    logic empty;
    logic busy;

    // Lanes are only enabled on a write.
    bus_decoder u_decoder (
        .address(bus_address),
        .read(bus_read),
        .write_mask(bus_write ? bus_write_mask : 4'b0000),
        .write_value(bus_write_value),
        .ram_bus(ram_bus.host),
        .io_bus(io_bus.host),
        .uart_bus(uart_bus.host),
        .read_value(bus_read_value),
        .ready(bus_ready),
        .fault(bus_fault)
    );

    ram u_ram (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .bus(ram_bus.target)
    );

    io_regs u_io (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .bus(io_bus.target),
        .leds(leds)
    );

    uart_regs u_uart_regs (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .bus(uart_bus.target),
        .full(full),
        .empty(empty),
        .busy(busy),
        .push(push),
        .push_data(push_data)
    );

    uart_fifo u_uart_fifo (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .push(push),
        .push_data(push_data),
        .pop(pop),
        .pop_data(pop_data),
        .full(full),
        .empty(empty)
    );

    uart_tx u_uart_tx (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .empty(empty),
        .pop_data(pop_data),
        .pop(pop),
        .busy(busy),
        .tx(uart_tx)
    );

endmodule

`default_nettype wire

// ==== verification/soc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_checker
    import soc_pkg::*;
(
    input logic pll_clk,
    input logic rst_n,
    input logic [31:0] bus_address,
    input logic bus_read,
    input logic bus_write,
    input logic [3:0] bus_write_mask,
    input logic [31:0] bus_write_value,
    input logic [31:0] bus_read_value,
    input logic bus_ready,
    input logic bus_fault,
    input logic [7:0] leds,
    input logic uart_tx
);

    int fail_count = 0;

    logic req;
    logic req_q;
    logic done_q;
    logic req_first;
    logic in_ram;
    logic unmapped;
    logic led_addr;
    logic lo_addr;
    logic hi_addr;
    logic data_addr;
    logic status_done;
    logic [RAM_ADDR_BITS-3:0] ram_idx;
    logic [31:0] shadow [RAM_WORDS];
    logic [31:0] shadow_word;
    logic [7:0] exp_leds;
    logic [31:0] last_lo;
    logic have_lo;
    logic [7:0] sent [16];
    logic [3:0] sent_wr;
    logic [3:0] sent_rd;
    logic [7:0] sent_head;
    logic push_pending;
    logic data_done;
    int accepted;
    int frames;
    int level;
    int idle_cnt;
    int rx_cnt;
    logic rx_busy;
    logic frame_done;
    logic [9:0] rx_bits;

    assign req = bus_read || bus_write;
    assign req_first = req && (!req_q || done_q);
    assign in_ram = (bus_address - RAM_BASE) < 32'(RAM_WORDS * 4);
    assign unmapped = !in_ram && (bus_address - IO_BASE) >= 32'(1 << REG_ADDR_BITS)
        && (bus_address - UART_BASE) >= 32'(1 << REG_ADDR_BITS);
    assign ram_idx = bus_address[RAM_ADDR_BITS-1:2];
    assign shadow_word = shadow[ram_idx];
    assign led_addr = bus_address == IO_BASE + {28'h0, IO_LEDS_OFS};
    assign lo_addr = bus_address == IO_BASE + {28'h0, IO_CYCLE_LO_OFS};
    assign hi_addr = bus_address == IO_BASE + {28'h0, IO_CYCLE_HI_OFS};
    assign data_addr = bus_address == UART_BASE + {28'h0, UART_DATA_OFS};
    assign status_done = bus_read && bus_ready
        && bus_address == UART_BASE + {28'h0, UART_STATUS_OFS};
    assign data_done = bus_write && bus_write_mask[0] && bus_ready && data_addr;
    assign sent_head = sent[sent_rd];

    // Bytes still queued are those accepted, less frames on the line and one not yet pushed.
    assign level = accepted - frames - (push_pending ? 1 : 0);

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            done_q <= 1'b0;
            exp_leds <= 8'h00;
            have_lo <= 1'b0;
            last_lo <= 32'h0;
            sent_wr <= 4'd0;
            accepted <= 0;
            push_pending <= 1'b0;
        end else begin
            req_q <= req;
            done_q <= req && bus_ready;
            push_pending <= data_done;
            if (bus_write && bus_write_mask[0] && bus_ready && led_addr) begin
                exp_leds <= bus_write_value[7:0];
            end
            if (bus_read && bus_ready && lo_addr) begin
                have_lo <= 1'b1;
                last_lo <= bus_read_value;
            end
            if (data_done) begin
                sent_wr <= sent_wr + 4'd1;
                accepted <= accepted + 1;
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus_write && bus_ready && in_ram) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_write_mask[lane]) begin
                    shadow[ram_idx][lane*8 +: 8] <= bus_write_value[lane*8 +: 8];
                end
            end
        end
        if (data_done) begin
            sent[sent_wr] <= bus_write_value[7:0];
        end
    end

    // Line sampler takes one sample per bit at its centre.
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_busy <= 1'b0;
            rx_cnt <= 0;
            rx_bits <= '0;
            frame_done <= 1'b0;
            frames <= 0;
            sent_rd <= 4'd0;
            idle_cnt <= 0;
        end else begin
            frame_done <= rx_busy && rx_cnt == 9 * UART_CLKS_PER_BIT + UART_CLKS_PER_BIT / 2;
            if (frame_done) begin
                sent_rd <= sent_rd + 4'd1;
            end
            idle_cnt <= (!rx_busy && uart_tx) ? idle_cnt + 1 : 0;
            if (!rx_busy) begin
                if (!uart_tx) begin
                    rx_busy <= 1'b1;
                    rx_cnt <= 1;
                    frames <= frames + 1;
                end
            end else begin
                rx_cnt <= rx_cnt + 1;
                if (rx_cnt % UART_CLKS_PER_BIT == UART_CLKS_PER_BIT / 2) begin
                    rx_bits <= {uart_tx, rx_bits[9:1]};
                end
                if (rx_cnt == 9 * UART_CLKS_PER_BIT + UART_CLKS_PER_BIT / 2) begin
                    rx_busy <= 1'b0;
                end
            end
        end
    end

    a_ram_wait: assert property (@(posedge pll_clk) disable iff (!rst_n)
        req_first && in_ram |-> !bus_ready)
        else begin
            $error("Mismatch at %0t: RAM ready in the first cycle of a request", $time);
            fail_count++;
        end

    a_ram_data: assert property (@(posedge pll_clk) disable iff (!rst_n)
        bus_read && bus_ready && in_ram |-> bus_read_value == shadow_word)
        else begin
            $error("Mismatch at %0t: RAM read data differs from shadow copy", $time);
            fail_count++;
        end

    a_unmapped: assert property (@(posedge pll_clk) disable iff (!rst_n)
        req && unmapped |-> bus_ready && bus_fault && bus_read_value == 32'h0)
        else begin
            $error("Mismatch at %0t: unmapped access without fault or with data", $time);
            fail_count++;
        end

    a_leds: assert property (@(posedge pll_clk) disable iff (!rst_n)
        leds == exp_leds && (bus_read && bus_ready && led_addr
        ? bus_read_value == {24'h0, exp_leds} : 1'b1))
        else begin
            $error("Mismatch at %0t: LED output or readback is wrong", $time);
            fail_count++;
        end

    a_cycle: assert property (@(posedge pll_clk) disable iff (!rst_n)
        bus_read && bus_ready && (hi_addr || (lo_addr && have_lo))
        |-> (hi_addr ? bus_read_value == 32'h0 : bus_read_value > last_lo))
        else begin
            $error("Mismatch at %0t: cycle counter read is wrong", $time);
            fail_count++;
        end

    a_frame: assert property (@(posedge pll_clk) disable iff (!rst_n)
        frame_done |-> sent_wr != sent_rd && rx_bits == {1'b1, sent_head, 1'b0})
        else begin
            $error("Mismatch at %0t: UART frame %0d does not match written byte", $time, frames);
            fail_count++;
        end

    a_status_busy: assert property (@(posedge pll_clk) disable iff (!rst_n)
        status_done && rx_busy |-> bus_read_value[1:0] == {1'b1, level == UART_FIFO_DEPTH})
        else begin
            $error("Mismatch at %0t: UART status during a frame", $time);
            fail_count++;
        end

    // An idle line means every written byte has left in a frame.
    a_status_idle: assert property (@(posedge pll_clk) disable iff (!rst_n)
        status_done && idle_cnt >= 10 * UART_CLKS_PER_BIT
        |-> !bus_read_value[1] && sent_rd == sent_wr)
        else begin
            $error("Mismatch at %0t: idle UART line with status pending or bytes not sent", $time);
            fail_count++;
        end

endmodule

bind soc_top soc_checker u_checker (
    .pll_clk(pll_clk),
    .rst_n(rst_n),
    .bus_address(bus_address),
    .bus_read(bus_read),
    .bus_write(bus_write),
    .bus_write_mask(bus_write_mask),
    .bus_write_value(bus_write_value),
    .bus_read_value(bus_read_value),
    .bus_ready(bus_ready),
    .bus_fault(bus_fault),
    .leds(leds),
    .uart_tx(uart_tx)
);

`default_nettype wire

// ==== verification/tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc
    import soc_pkg::*;
();

    logic pll_clk;
    logic rst_n;
    logic [31:0] bus_address;
    logic bus_read;
    logic bus_write;
    logic [3:0] bus_write_mask;
    logic [31:0] bus_write_value;
    logic [31:0] bus_read_value;
    logic bus_ready;
    logic bus_fault;
    logic [7:0] leds;
    logic uart_tx;

    int seed = 32'h6844;
    int incomplete;
    int tests;
    int cycles;
    int cycle_limit;

    soc_top u_dut (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .bus_address(bus_address),
        .bus_read(bus_read),
        .bus_write(bus_write),
        .bus_write_mask(bus_write_mask),
        .bus_write_value(bus_write_value),
        .bus_read_value(bus_read_value),
        .bus_ready(bus_ready),
        .bus_fault(bus_fault),
        .leds(leds),
        .uart_tx(uart_tx)
    );

    initial begin
        pll_clk = 1'b0;
        forever #5 pll_clk = ~pll_clk;
    end

    // Six UART frames dominate the run; the register tests need far less.
    initial begin
        cycle_limit = 6 * 10 * UART_CLKS_PER_BIT + 1040;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge pll_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    // Called on a falling edge; returns on the falling edge after completion.
    task automatic transfer(input logic [31:0] addr, input logic wr, input logic [3:0] mask,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        rdata = 32'h0;
        bus_address = addr;
        bus_read = !wr;
        bus_write = wr;
        bus_write_mask = mask;
        bus_write_value = wdata;
        while (!done && waited < 20 * UART_CLKS_PER_BIT) begin
            @(posedge pll_clk);
            done = bus_ready;
            rdata = bus_read_value;
            waited++;
        end
        @(negedge pll_clk);
        bus_read = 1'b0;
        bus_write = 1'b0;
        bus_write_mask = 4'h0;
        if (!done) begin
            incomplete++;
            $display("Transfer to address 0x%08h never completed, given up at %0t", addr, $time);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] wdata);
        logic [31:0] unused_data;
        transfer(addr, 1'b1, mask, wdata, unused_data);
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] rdata);
        transfer(addr, 1'b0, 4'h0, 32'h0, rdata);
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        $display("%s finished at %0t, %0d transfers never completed", name, $time,
                 incomplete - mark);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] rdata;
        logic [31:0] addr;
        logic [3:0] mask;
        int mark;
        int polls;
        int checker_fails;
        rst_n = 1'b0;
        bus_address = 32'h0;
        bus_read = 1'b0;
        bus_write = 1'b0;
        bus_write_mask = 4'h0;
        bus_write_value = 32'h0;
        incomplete = 0;
        tests = 0;
        repeat (3) @(negedge pll_clk);
        rst_n = 1'b1;
        @(negedge pll_clk);

        mark = incomplete;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            addr = RAM_BASE + {22'h0, r[7:0], 2'b00};
            mask = (r[11:8] == 4'h0) ? 4'b1000 : r[11:8];
            write_word(addr, 4'hF, $random(seed));
            write_word(addr, mask, $random(seed));
            read_word(addr, rdata);
        end
        report_test("ram", mark);

        mark = incomplete;
        read_word(32'h0005_0000, rdata);
        read_word(32'h0000_0400, rdata);
        write_word(32'h0005_0000, 4'hF, 32'hDEAD_BEEF);
        report_test("unmapped", mark);

        mark = incomplete;
        for (int i = 0; i < 2; i++) begin
            write_word(IO_BASE + {28'h0, IO_LEDS_OFS}, 4'b0001, $random(seed));
            read_word(IO_BASE + {28'h0, IO_LEDS_OFS}, rdata);
        end
        report_test("leds", mark);

        mark = incomplete;
        read_word(IO_BASE + {28'h0, IO_CYCLE_LO_OFS}, rdata);
        read_word(IO_BASE + {28'h0, IO_CYCLE_LO_OFS}, rdata);
        read_word(IO_BASE + {28'h0, IO_CYCLE_HI_OFS}, rdata);
        report_test("cycle counter", mark);

        mark = incomplete;
        for (int i = 0; i < 6; i++) begin
            write_word(UART_BASE + {28'h0, UART_DATA_OFS}, 4'b0001, $random(seed));
        end
        // The last byte reaches the FIFO one cycle after its write.
        @(negedge pll_clk);
        read_word(UART_BASE + {28'h0, UART_STATUS_OFS}, rdata);
        polls = 0;
        while (rdata[1] && polls < 1000) begin
            read_word(UART_BASE + {28'h0, UART_STATUS_OFS}, rdata);
            polls++;
        end
        if (rdata[1]) begin
            incomplete++;
            $display("UART still pending after %0d status reads", polls);
        end
        repeat (10 * UART_CLKS_PER_BIT) @(negedge pll_clk);
        read_word(UART_BASE + {28'h0, UART_STATUS_OFS}, rdata);
        report_test("uart", mark);

        checker_fails = u_dut.u_checker.fail_count;
        $display("Summary: %0d tests, %0d incomplete transfers, %0d assertion failures",
                 tests, incomplete, checker_fails);
        if (incomplete == 0 && checker_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/soc_pkg.sv
rtl/mem_bus_if.sv
rtl/bus_decoder.sv
rtl/ram.sv
rtl/io_regs.sv
rtl/uart_regs.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/soc_top.sv
verification/soc_checker.sv
verification/tb_soc.sv

// ==== Makefile ====
TOP = tb_soc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@if ! grep -q "test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
